//--- axil_noc_bridge.sv
`timescale 1ns/1ps

module axil_noc_bridge
    import axil_pkg::*;
    import noc_msg_pkg::*;
#(
    parameter int FIFO_DEPTH = 16
) (
    input  logic       clk,
    input  logic       rst_n,
    input  axil_addr_t awaddr,
    input  logic       awvalid,
    output logic       awready,
    input  axil_data_t wdata,
    input  axil_strb_t wstrb,
    input  logic       wvalid,
    output logic       wready,
    input  axil_addr_t araddr,
    input  logic       arvalid,
    output logic       arready,
    input  node_id_t   src_id,
    input  node_id_t   dst_id,
    output logic       noc_valid,
    output flit_t      noc_data,
    input  logic       noc_ready
);

    axil_req_t head;
    logic      head_valid;
    logic      pop;
    noc_msg_t  msg;
    logic      msg_valid;
    logic      msg_taken;

    axil_request_intake #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_axil_request_intake (
        .clk        (clk),
        .rst_n      (rst_n),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wvalid     (wvalid),
        .wready     (wready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .pop        (pop),
        .head       (head),
        .head_valid (head_valid)
    );

    noc_message_builder i_noc_message_builder (
        .clk        (clk),
        .rst_n      (rst_n),
        .head       (head),
        .head_valid (head_valid),
        .pop        (pop),
        .msg        (msg),
        .msg_valid  (msg_valid),
        .msg_taken  (msg_taken)
    );

    flit_serializer i_flit_serializer (
        .clk       (clk),
        .rst_n     (rst_n),
        .msg       (msg),
        .msg_valid (msg_valid),
        .msg_taken (msg_taken),
        .src_id    (src_id),
        .dst_id    (dst_id),
        .noc_valid (noc_valid),
        .noc_data  (noc_data),
        .noc_ready (noc_ready)
    );

endmodule

//--- axil_pkg.sv
package axil_pkg;

    typedef logic [63:0] axil_addr_t;
    typedef logic [63:0] axil_data_t;
    typedef logic [7:0]  axil_strb_t;

    typedef enum logic {
        req_store,
        req_load
    } req_kind_t;

    // loads carry zero data and strobe
    typedef struct packed {
        req_kind_t  kind;
        axil_addr_t addr;
        axil_data_t data;
        axil_strb_t strb;
    } axil_req_t;

endpackage

//--- axil_request_intake.sv
`timescale 1ns/1ps

module axil_request_intake import axil_pkg::*; #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic       clk,
    input  logic       rst_n,
    input  axil_addr_t awaddr,
    input  logic       awvalid,
    output logic       awready,
    input  axil_data_t wdata,
    input  axil_strb_t wstrb,
    input  logic       wvalid,
    output logic       wready,
    input  axil_addr_t araddr,
    input  logic       arvalid,
    output logic       arready,
    input  logic       pop,
    output axil_req_t  head,
    output logic       head_valid
);

    logic      full;
    logic      write_req;
    logic      push;
    axil_req_t push_req;

    // a write needs both address and data in the same cycle
    assign write_req = awvalid && wvalid;

    // each half of a write waits for its partner
    assign awready = !full && !(awvalid && !wvalid);
    assign wready  = !full && !(wvalid && !awvalid);
    assign arready = !full && !write_req;  // write wins

    assign push = !full && (write_req || arvalid);

    always_comb begin
        if (write_req) begin
            push_req.kind = req_store;
            push_req.addr = awaddr;
            push_req.data = wdata;
            push_req.strb = wstrb;
        end else begin
            push_req.kind = req_load;
            push_req.addr = araddr;
            push_req.data = '0;
            push_req.strb = '0;
        end
    end

    request_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_request_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_req  (push_req),
        .pop       (pop),
        .head      (head),
        .not_empty (head_valid),
        .full      (full)
    );

endmodule

//--- files.f
noc_msg_pkg.sv
axil_pkg.sv
request_fifo.sv
axil_request_intake.sv
noc_message_builder.sv
flit_serializer.sv
axil_noc_bridge.sv
tb_axil_noc_bridge.sv

//--- flit_serializer.sv
`timescale 1ns/1ps

module flit_serializer import noc_msg_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  noc_msg_t msg,
    input  logic     msg_valid,
    output logic     msg_taken,
    input  node_id_t src_id,
    input  node_id_t dst_id,
    output logic     noc_valid,
    output flit_t    noc_data,
    input  logic     noc_ready
);

    typedef enum logic [1:0] {
        st_idle,
        st_header,
        st_data
    } state_t;

    state_t     state;
    state_t     state_next;
    logic [1:0] flit_cnt;
    logic [1:0] flit_cnt_next;
    logic       xfer;
    logic       last_hdr;
    logic       last_data;

    // header state with no message only happens right after a finished message
    assign noc_valid = (state == st_data) || ((state == st_header) && msg_valid);
    assign xfer      = noc_valid && noc_ready;

    assign last_hdr  = (flit_cnt == 2'(HDR_FLITS - 1));
    assign last_data = (msg_len_t'(flit_cnt) == msg.length - msg_len_t'(HDR_FLITS));
    assign msg_taken = xfer && (state == st_data) && last_data;

    always_comb begin
        state_next    = state;
        flit_cnt_next = flit_cnt;
        case (state)
            st_idle: begin
                if (msg_valid) begin
                    state_next    = st_header;
                    flit_cnt_next = '0;
                end
            end
            st_header: begin
                if (!msg_valid) begin
                    state_next = st_idle;
                end else if (xfer) begin
                    flit_cnt_next = last_hdr ? 2'd0 : flit_cnt + 2'd1;
                    if (last_hdr) begin
                        state_next = st_data;
                    end
                end
            end
            st_data: begin
                if (xfer) begin
                    flit_cnt_next = last_data ? 2'd0 : flit_cnt + 2'd1;
                    if (last_data) begin
                        state_next = st_header;  // next message starts back to back
                    end
                end
            end
            default: state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= st_idle;
            flit_cnt <= '0;
        end else begin
            state    <= state_next;
            flit_cnt <= flit_cnt_next;
        end
    end

    always_comb begin
        noc_data = '0;
        if (state == st_header) begin
            case (flit_cnt)
                2'd0:    noc_data = {dst_id, msg.length, msg.msg_type, 14'b0};
                2'd1:    noc_data = {msg.addr, msg.data_size, 13'b0, msg.byte_mask};
                default: noc_data = {src_id, 30'b0};
            endcase
        end else if (state == st_data) begin
            noc_data = msg.data;  // zero for loads
        end
    end

endmodule

//--- noc_message_builder.sv
`timescale 1ns/1ps

module noc_message_builder
    import axil_pkg::*;
    import noc_msg_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  axil_req_t head,
    input  logic      head_valid,
    output logic      pop,
    output noc_msg_t  msg,
    output logic      msg_valid,
    input  logic      msg_taken
);

    noc_msg_t msg_next;
    logic     is_store;

    // refill in the same cycle the serializer releases the register
    assign pop = head_valid && (!msg_valid || msg_taken);

    assign is_store = (head.kind == req_store);

    always_comb begin
        msg_next.msg_type = MSG_TYPE_SWAPWB;
        msg_next.addr     = head.addr[$bits(phy_addr_t)-1:0];
        if (is_store) begin
            msg_next.length    = STORE_LEN;
            msg_next.data_size = DATA_SIZE_8B;
            // one mask bit per byte, mirrored along with the data bytes
            msg_next.byte_mask = {<<{head.strb}};
            msg_next.data      = {<<8{head.data}};  // little to big endian
        end else begin
            msg_next.length    = LOAD_LEN;
            msg_next.data_size = DATA_SIZE_16B;    // L2 wants at least 16 bytes
            msg_next.byte_mask = '0;
            msg_next.data      = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            msg <= msg_next;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            msg_valid <= 1'b0;
        end else if (pop) begin
            msg_valid <= 1'b1;
        end else if (msg_taken) begin
            msg_valid <= 1'b0;
        end
    end

endmodule

//--- noc_msg_pkg.sv
package noc_msg_pkg;

    typedef logic [63:0] flit_t;
    typedef logic [13:0] chipid_t;
    typedef logic [7:0]  xy_t;
    typedef logic [3:0]  fbits_t;
    typedef logic [7:0]  msg_len_t;     // flits after the first header flit
    typedef logic [7:0]  msg_type_t;
    typedef logic [2:0]  data_size_t;
    typedef logic [39:0] phy_addr_t;
    typedef logic [7:0]  byte_mask_t;

    // swap-writeback request served by the L2
    localparam msg_type_t MSG_TYPE_SWAPWB = 8'd35;

    localparam data_size_t DATA_SIZE_8B  = 3'b100;
    localparam data_size_t DATA_SIZE_16B = 3'b101;

    localparam msg_len_t STORE_LEN = 8'd3;  // 2 headers + 1 data flit
    localparam msg_len_t LOAD_LEN  = 8'd4;  // 2 headers + 2 zero flits

    localparam int HDR_FLITS = 3;

    // tile identity for both source and destination
    typedef struct packed {
        chipid_t chipid;
        xy_t     x;
        xy_t     y;
        fbits_t  fbits;
    } node_id_t;

    typedef struct packed {
        msg_type_t  msg_type;
        msg_len_t   length;
        data_size_t data_size;
        phy_addr_t  addr;
        byte_mask_t byte_mask;
        flit_t      data;           // already in NoC byte order
    } noc_msg_t;

endpackage

//--- request_fifo.sv
`timescale 1ns/1ps

module request_fifo import axil_pkg::*; #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      push,
    input  axil_req_t push_req,
    input  logic      pop,
    output axil_req_t head,
    output logic      not_empty,
    output logic      full
);

    localparam int ADDR_W = $clog2(FIFO_DEPTH);

    axil_req_t         mem [FIFO_DEPTH];
    logic [ADDR_W:0]   wr_ptr;
    logic [ADDR_W:0]   rd_ptr;
    logic              do_push;
    logic              do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && not_empty;

    // extra pointer bit separates full from empty
    assign not_empty = (wr_ptr != rd_ptr);
    assign full      = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                       (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

    assign head = mem[rd_ptr[ADDR_W-1:0]];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[ADDR_W-1:0]] <= push_req;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_axil_noc_bridge -f files.f

out=$(./obj_dir/Vtb_axil_noc_bridge)
echo "$out"
echo "$out" | grep -q "RESULT: PASS"

//--- tb_axil_noc_bridge.sv
`timescale 1ns/1ps

module tb_axil_noc_bridge
    import axil_pkg::*;
    import noc_msg_pkg::*;
();

    localparam int FIFO_DEPTH = 16;
    localparam int TIMEOUT    = 400;   // cycles allowed per wait

    logic       clk;
    logic       rst_n;
    axil_addr_t awaddr;
    logic       awvalid;
    logic       awready;
    axil_data_t wdata;
    axil_strb_t wstrb;
    logic       wvalid;
    logic       wready;
    axil_addr_t araddr;
    logic       arvalid;
    logic       arready;
    node_id_t   src_id;
    node_id_t   dst_id;
    logic       noc_valid;
    flit_t      noc_data;
    logic       noc_ready;

    axil_req_t   exp_q[$];              // accepted requests in acceptance order
    flit_t       got_q[$];              // flits transferred on the NoC port
    int          errors;
    int          checks;
    logic [31:0] rnd_state;
    logic [31:0] bp_state;
    logic        bp_on;
    logic        stalled;
    flit_t       stalled_flit;

    axil_noc_bridge #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_axil_noc_bridge (
        .clk       (clk),
        .rst_n     (rst_n),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wvalid    (wvalid),
        .wready    (wready),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .src_id    (src_id),
        .dst_id    (dst_id),
        .noc_valid (noc_valid),
        .noc_data  (noc_data),
        .noc_ready (noc_ready)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rnd_state = xorshift32(rnd_state);
        return rnd_state;
    endfunction

    function automatic logic [63:0] rand64();
        logic [31:0] hi;
        hi = next_rand();
        return {hi, next_rand()};
    endfunction

    function automatic axil_req_t make_req(input req_kind_t kind, input axil_addr_t addr,
                                           input axil_data_t data, input axil_strb_t strb);
        axil_req_t req;
        req.kind = kind;
        req.addr = addr;
        req.data = data;
        req.strb = strb;
        return req;
    endfunction

    // flit idx of the message for one request per the NoC flit layout
    function automatic flit_t expected_flit(input axil_req_t req, input int idx);
        msg_len_t   len;
        data_size_t size;
        byte_mask_t mask;
        flit_t      swapped;
        flit_t      flit;
        for (int b = 0; b < 8; b++) begin
            mask[b]           = req.strb[7-b];
            swapped[8*b +: 8] = req.data[8*(7-b) +: 8];
        end
        len  = (req.kind == req_store) ? 8'd3 : 8'd4;
        size = (req.kind == req_store) ? DATA_SIZE_8B : DATA_SIZE_16B;
        case (idx)
            0:       flit = {dst_id, len, MSG_TYPE_SWAPWB, 14'b0};
            1:       flit = {req.addr[39:0], size, 13'b0, mask};
            2:       flit = {src_id, 30'b0};
            3:       flit = (req.kind == req_store) ? swapped : '0;
            default: flit = '0;
        endcase
        return flit;
    endfunction

    task automatic check_flit(input string name, input flit_t got, input flit_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error: %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_valid(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error: %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("error: %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic finish_run();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    endtask

    task automatic timed_out(input string what);
        errors++;
        $display("timeout while waiting for %s", what);
        finish_run();
    endtask

    // records every transfer and checks that a stalled flit holds
    always @(posedge clk) begin
        if (rst_n) begin
            if (stalled) begin
                check_valid("noc_valid", noc_valid, 1'b1);
                check_flit("noc_data", noc_data, stalled_flit);
            end
            if (noc_valid && noc_ready) begin
                got_q.push_back(noc_data);
            end
            stalled      = noc_valid && !noc_ready;
            stalled_flit = noc_data;
        end
    end

    always @(posedge clk) begin
        #2;
        if (bp_on) begin
            bp_state  = xorshift32(bp_state);
            noc_ready = bp_state[0] | bp_state[1];  // ready about 3 cycles in 4
        end
    end

    task automatic wait_write();
        logic accepted;
        int   waited;
        accepted = 1'b0;
        waited   = 0;
        while (!accepted && waited < TIMEOUT) begin
            @(posedge clk);
            accepted = awready && wready;
            waited++;
        end
        if (!accepted) begin
            timed_out("write acceptance");
        end else begin
            if (arvalid) begin
                check_valid("arready", arready, 1'b0);  // write goes first
            end
            exp_q.push_back(make_req(req_store, awaddr, wdata, wstrb));
            #2;
            awvalid = 1'b0;
            wvalid  = 1'b0;
        end
    endtask

    task automatic wait_read();
        logic accepted;
        int   waited;
        accepted = 1'b0;
        waited   = 0;
        while (!accepted && waited < TIMEOUT) begin
            @(posedge clk);
            accepted = arready;
            waited++;
        end
        if (!accepted) begin
            timed_out("read acceptance");
        end else begin
            exp_q.push_back(make_req(req_load, araddr, '0, '0));
            #2;
            arvalid = 1'b0;
        end
    endtask

    task automatic do_write();
        awaddr  = rand64();
        wdata   = rand64();
        wstrb   = axil_strb_t'(next_rand());
        awvalid = 1'b1;
        wvalid  = 1'b1;
        wait_write();
    endtask

    task automatic do_read();
        araddr  = rand64();
        arvalid = 1'b1;
        wait_read();
    endtask

    task automatic do_write_read();
        araddr  = rand64();
        arvalid = 1'b1;
        do_write();
        wait_read();
    endtask

    task automatic issue_random_mix(input int n);
        int pick;
        for (int i = 0; i < n; i++) begin
            pick = int'(next_rand() % 3);
            case (pick)
                0:       do_write();
                1:       do_read();
                default: do_write_read();
            endcase
        end
    endtask

    task automatic collect_message();
        axil_req_t req;
        int        n;
        int        waited;
        req    = exp_q.pop_front();
        n      = (req.kind == req_store) ? 4 : 5;
        waited = 0;
        while (got_q.size() < n && waited < TIMEOUT) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (got_q.size() < n) begin
            timed_out("message flits");
        end else begin
            for (int i = 0; i < n; i++) begin
                check_flit("noc_data", got_q.pop_front(), expected_flit(req, i));
            end
        end
    endtask

    task automatic collect_all();
        while (exp_q.size() > 0) begin
            collect_message();
        end
        repeat (4) @(posedge clk);
        #2;
        check_count("extra flits", got_q.size(), 0);
        got_q.delete();
    endtask

    task automatic test_reset_state();
        check_valid("noc_valid", noc_valid, 1'b0);
        check_valid("awready", awready, 1'b1);
        check_valid("wready", wready, 1'b1);
        check_valid("arready", arready, 1'b1);
    endtask

    task automatic test_backpressure();
        bp_state = next_rand();
        bp_on    = 1'b1;
        issue_random_mix(16);
        collect_all();
        bp_on     = 1'b0;
        noc_ready = 1'b1;
    endtask

    task automatic test_full_queue();
        int   accepted_n;
        logic full_seen;
        int   waited;
        noc_ready  = 1'b0;
        accepted_n = 0;
        full_seen  = 1'b0;
        waited     = 0;
        awvalid    = 1'b1;
        wvalid     = 1'b1;
        while (!full_seen && waited < TIMEOUT) begin
            awaddr = rand64();
            wdata  = rand64();
            wstrb  = axil_strb_t'(next_rand());
            @(posedge clk);
            if (awready && wready) begin
                exp_q.push_back(make_req(req_store, awaddr, wdata, wstrb));
                accepted_n++;
            end else begin
                full_seen = 1'b1;
            end
            waited++;
            #2;
        end
        if (!full_seen) begin
            timed_out("a full request queue");
        end else begin
            awvalid = 1'b0;
            wvalid  = 1'b0;
            // FIFO entries plus the one held in the message register
            check_count("accepted requests", accepted_n, FIFO_DEPTH + 1);
            check_valid("awready", awready, 1'b0);
            check_valid("wready", wready, 1'b0);
            check_valid("arready", arready, 1'b0);
            noc_ready = 1'b1;
            collect_all();
        end
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        awaddr    = '0;
        awvalid   = 1'b0;
        wdata     = '0;
        wstrb     = '0;
        wvalid    = 1'b0;
        araddr    = '0;
        arvalid   = 1'b0;
        noc_ready = 1'b1;
        src_id    = {14'h0012, 8'h01, 8'h02, 4'h3};
        dst_id    = {14'h2a5c, 8'h07, 8'h04, 4'h9};
        bp_on     = 1'b0;
        bp_state  = '0;
        stalled   = 1'b0;
        errors    = 0;
        checks    = 0;
        rnd_state = 32'd46662;
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
        test_reset_state();
        do_write();            // single store
        collect_all();
        do_read();             // single load
        collect_all();
        do_write_read();       // order and priority
        issue_random_mix(12);
        collect_all();
        test_backpressure();
        test_full_queue();
        finish_run();
    end

endmodule
